/* source/tern_pkg.sv */
`default_nettype none

package tern_pkg;

  parameter int WORD_W   = 64;  // Memory word width
  parameter int ADDR_W   = 8;   // 256-word shared memory
  parameter int N_ELEM   = 16;  // Elements per vector
  parameter int X_ELEM_W = 8;   // Signed activation element
  parameter int TRIT_W   = 4;   // Weight field, read as signed

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [ADDR_W-1:0] addr_t;  // Wraps modulo 256

  // Element i at bits 8i upward, word 0 is the low half
  typedef logic [N_ELEM*X_ELEM_W-1:0] x_vec_t;
  // Field i at bits 4i upward, one word
  typedef logic [N_ELEM*TRIT_W-1:0] w_vec_t;

  typedef logic signed [15:0] sum_t;  // Dot product, max magnitude 2048

  typedef struct packed {
    addr_t addr;   // Word address
    word_t wdata;  // Write data, ignored on reads
    logic  we;     // 1 write, 0 read
  } mem_req_t;

  typedef struct packed {
    addr_t x_base;  // First of two activation words
    addr_t w_base;  // Weight word
  } run_cmd_t;

  parameter logic [7:0] OP_WRITE = 8'h01;  // addr, 8 data bytes LSB first
  parameter logic [7:0] OP_RUN   = 8'h02;  // x base, w base

endpackage

`default_nettype wire

/* source/uart_rx.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_rx #(
  parameter int CLKS_PER_BIT = 868
) (
  input  logic       clk_100mhz,
  input  logic       rst_n,
  input  logic       rxd,
  output logic [7:0] byte_data,
  output logic       byte_valid
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
  localparam logic [CNT_W-1:0] HALF = CNT_W'(CLKS_PER_BIT / 2 - 1);  // Start bit midpoint
  localparam logic [CNT_W-1:0] FULL = CNT_W'(CLKS_PER_BIT - 1);      // One bit period

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

  rx_state_t        state;
  logic [1:0]       sync;     // Two-flop synchronizer, line idles high
  logic [CNT_W-1:0] cnt;      // Cycles within current bit
  logic [2:0]       bit_idx;  // Data bit being sampled
  logic             rx;

  assign rx = sync[1];

  always_ff @(posedge clk_100mhz or negedge rst_n) begin
    if (!rst_n) begin
      sync       <= 2'b11;
      state      <= RX_IDLE;
      cnt        <= '0;
      bit_idx    <= '0;
      byte_data  <= '0;
      byte_valid <= 1'b0;
    end else begin
      sync       <= {sync[0], rxd};
      byte_valid <= 1'b0;  // Pulse only
      case (state)
        RX_IDLE: begin
          cnt <= '0;
          if (!rx) state <= RX_START;  // Falling edge of start bit
        end
        RX_START: begin
          if (cnt == HALF) begin
            cnt     <= '0;
            bit_idx <= '0;
            state   <= rx ? RX_IDLE : RX_DATA;  // Glitch, not a real start
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        RX_DATA: begin
          if (cnt == FULL) begin
            cnt       <= '0;
            byte_data <= {rx, byte_data[7:1]};  // LSB arrives first
            bit_idx   <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) state <= RX_STOP;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        RX_STOP: begin
          if (cnt == FULL) begin
            cnt        <= '0;
            state      <= RX_IDLE;
            byte_valid <= rx;  // Framing error drops the byte
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/cmd_loader.sv */
`timescale 1ns/10ps
`default_nettype none

module cmd_loader import tern_pkg::*; (
  input  logic       clk_100mhz,
  input  logic       rst_n,
  input  logic [7:0] byte_data,
  input  logic       byte_valid,
  output logic       wr_req,
  output mem_req_t   wr_bus,
  input  logic       wr_gnt,
  output logic       run,
  output run_cmd_t   run_cmd
);

  typedef enum logic [2:0] {
    LD_OP,     // Waiting for opcode
    LD_ADDR,   // Write address byte
    LD_DATA,   // Eight data bytes
    LD_WRITE,  // Request held until granted
    LD_XBASE,  // Activation base byte
    LD_WBASE   // Weight base byte
  } ld_state_t;

  ld_state_t  state;
  logic [2:0] byte_cnt;  // Data bytes taken so far
  addr_t      wr_addr;
  word_t      wr_data;   // Assembled LSB first

  always_comb begin
    wr_bus.addr  = wr_addr;
    wr_bus.wdata = wr_data;
    wr_bus.we    = 1'b1;  // Loader only writes
  end

  always_ff @(posedge clk_100mhz or negedge rst_n) begin
    if (!rst_n) begin
      state    <= LD_OP;
      byte_cnt <= '0;
      wr_req   <= 1'b0;
      run      <= 1'b0;
    end else begin
      run <= 1'b0;
      case (state)
        LD_OP: begin
          if (byte_valid) begin
            if (byte_data == OP_WRITE) state <= LD_ADDR;
            else if (byte_data == OP_RUN) state <= LD_XBASE;
            // Unknown opcodes fall through, still waiting
          end
        end
        LD_ADDR: begin
          if (byte_valid) begin
            byte_cnt <= '0;
            state    <= LD_DATA;
          end
        end
        LD_DATA: begin
          if (byte_valid) begin
            byte_cnt <= byte_cnt + 1'b1;
            if (byte_cnt == 3'd7) begin
              wr_req <= 1'b1;  // Full word in hand
              state  <= LD_WRITE;
            end
          end
        end
        LD_WRITE: begin
          if (wr_gnt) begin  // Top priority, same-cycle grant
            wr_req <= 1'b0;
            state  <= LD_OP;
          end
        end
        LD_XBASE: if (byte_valid) state <= LD_WBASE;
        LD_WBASE: begin
          if (byte_valid) begin
            run   <= 1'b1;  // One cycle after last byte
            state <= LD_OP;
          end
        end
        default: state <= LD_OP;
      endcase
    end
  end

  // Command payload capture
  always_ff @(posedge clk_100mhz) begin
    if (byte_valid) begin
      if (state == LD_ADDR) wr_addr <= byte_data;
      if (state == LD_DATA) wr_data <= {byte_data, wr_data[WORD_W-1:8]};
      if (state == LD_XBASE) run_cmd.x_base <= byte_data;
      if (state == LD_WBASE) run_cmd.w_base <= byte_data;
    end
  end

endmodule

`default_nettype wire

/* source/mem_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_arbiter import tern_pkg::*; (
  input  logic     clk_100mhz,
  input  logic     rst_n,
  input  logic     wr_req,
  input  mem_req_t wr_bus,
  output logic     wr_gnt,
  input  logic     x_req,
  input  mem_req_t x_bus,
  output logic     x_gnt,
  output logic     x_rvalid,
  input  logic     w_req,
  input  mem_req_t w_bus,
  output logic     w_gnt,
  output logic     w_rvalid,
  output word_t    rdata,
  output mem_req_t ram_bus,
  output logic     ram_en,
  input  word_t    ram_rdata
);

  typedef struct packed {
    logic x;  // Read issued by activation gatherer
    logic w;  // Read issued by weight gatherer
  } rd_tag_t;

  rd_tag_t tag_s1, tag_s2;  // One stage per RAM register

  // Fixed priority, loader > activation > weight
  assign wr_gnt = wr_req;
  assign x_gnt  = x_req & ~wr_req;
  assign w_gnt  = w_req & ~wr_req & ~x_req;
  assign ram_en = wr_req | x_req | w_req;

  always_comb begin
    if (wr_req) ram_bus = wr_bus;
    else if (x_req) ram_bus = x_bus;
    else ram_bus = w_bus;  // Also the idle value, ram_en low
  end

  always_ff @(posedge clk_100mhz or negedge rst_n) begin
    if (!rst_n) begin
      tag_s1 <= '0;
      tag_s2 <= '0;
    end else begin
      tag_s1.x <= x_gnt & ~x_bus.we;
      tag_s1.w <= w_gnt & ~w_bus.we;
      tag_s2   <= tag_s1;  // Lines up with RAM output register
    end
  end

  assign x_rvalid = tag_s2.x;
  assign w_rvalid = tag_s2.w;
  assign rdata    = ram_rdata;  // Shared return, rvalid picks the owner

endmodule

`default_nettype wire

/* source/word_ram.sv */
`timescale 1ns/10ps
`default_nettype none

module word_ram import tern_pkg::*; (
  input  logic     clk_100mhz,
  input  logic     ram_en,
  input  mem_req_t ram_bus,
  output word_t    ram_rdata
);

  localparam int DEPTH = 2 ** ADDR_W;  // Full address range

  word_t mem [DEPTH];
  word_t rd_q;  // Array read register

  always_ff @(posedge clk_100mhz) begin
    if (ram_en) begin
      if (ram_bus.we) begin
        mem[ram_bus.addr] <= ram_bus.wdata;
      end else begin
        rd_q <= mem[ram_bus.addr];  // First stage
      end
    end
    ram_rdata <= rd_q;  // Output register, data two cycles after request
  end

endmodule

`default_nettype wire

/* source/word_gatherer.sv */
`timescale 1ns/10ps
`default_nettype none

module word_gatherer import tern_pkg::*; #(
  parameter type payload_t = word_t
) (
  input  logic     clk_100mhz,
  input  logic     rst_n,
  input  logic     start,
  input  addr_t    base,
  output logic     req,
  output mem_req_t bus,
  input  logic     gnt,
  input  logic     rvalid,
  input  word_t    rdata,
  output logic     done,
  output payload_t payload
);

  localparam int PL_W   = $bits(payload_t);
  localparam int PIECES = PL_W / WORD_W;               // Words per payload
  localparam int CNT_W  = $clog2(PIECES + 1);
  localparam int IDX_W  = (PIECES > 1) ? $clog2(PIECES) : 1;

  logic [CNT_W-1:0] issue_cnt;  // Reads granted, PIECES when idle
  logic [IDX_W-1:0] ret_idx;    // Slot for next returning word
  logic             last_ret;
  addr_t            addr_q;     // Next address to request
  addr_t            cur_addr;
  logic [PL_W-1:0]  pl_q;

  // First request goes out in the start cycle
  assign cur_addr = start ? base : addr_q;
  assign req      = start | (issue_cnt != CNT_W'(PIECES));
  assign last_ret = (ret_idx == IDX_W'(PIECES - 1));
  assign payload  = pl_q;

  always_comb begin
    bus.addr  = cur_addr;
    bus.wdata = '0;
    bus.we    = 1'b0;  // Read only
  end

  always_ff @(posedge clk_100mhz or negedge rst_n) begin
    if (!rst_n) begin
      issue_cnt <= CNT_W'(PIECES);
      ret_idx   <= '0;
      done      <= 1'b0;
    end else begin
      if (start) issue_cnt <= gnt ? CNT_W'(1) : '0;
      else if (req && gnt) issue_cnt <= issue_cnt + 1'b1;
      done <= rvalid & last_ret;  // Payload complete next cycle
      if (rvalid) ret_idx <= last_ret ? '0 : ret_idx + 1'b1;
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (req && gnt) addr_q <= cur_addr + addr_t'(1);  // Wraps past 255
    else if (start) addr_q <= base;                   // Held until granted
    if (rvalid) pl_q[ret_idx*WORD_W +: WORD_W] <= rdata;
  end

endmodule

`default_nettype wire

/* source/ternary_dot.sv */
`timescale 1ns/10ps
`default_nettype none

module ternary_dot import tern_pkg::*; (
  input  logic     clk_100mhz,
  input  logic     rst_n,
  input  logic     run,
  input  run_cmd_t run_cmd,
  output logic     x_start,
  output addr_t    x_base,
  input  logic     x_done,
  input  x_vec_t   x_vec,
  output logic     w_start,
  output addr_t    w_base,
  input  logic     w_done,
  input  w_vec_t   w_vec,
  output sum_t     result,
  output logic     result_valid
);

  typedef enum logic [1:0] {DOT_IDLE, DOT_X, DOT_W} dot_state_t;

  dot_state_t state;
  sum_t       dot;  // Combinational dot product

  always_comb begin : dot_sum
    sum_t                       acc;
    logic signed [X_ELEM_W-1:0] xe;
    logic signed [TRIT_W-1:0]   te;
    acc = '0;
    for (int i = 0; i < N_ELEM; i++) begin
      xe = x_vec[i*X_ELEM_W +: X_ELEM_W];
      te = w_vec[i*TRIT_W +: TRIT_W];
      if (te > 0) acc = acc + sum_t'(xe);       // Trit +1
      else if (te < 0) acc = acc - sum_t'(xe);  // Trit -1, zero field skipped
    end
    dot = acc;
  end

  always_ff @(posedge clk_100mhz or negedge rst_n) begin
    if (!rst_n) begin
      state        <= DOT_IDLE;
      x_start      <= 1'b0;
      w_start      <= 1'b0;
      result       <= '0;
      result_valid <= 1'b0;
    end else begin
      x_start      <= 1'b0;
      w_start      <= 1'b0;
      result_valid <= 1'b0;
      case (state)
        DOT_IDLE: begin
          if (run) begin  // Runs while busy are dropped
            x_start <= 1'b1;
            state   <= DOT_X;
          end
        end
        DOT_X: begin
          if (x_done) begin
            w_start <= 1'b1;  // Activations held in gatherer
            state   <= DOT_W;
          end
        end
        DOT_W: begin
          if (w_done) begin
            result       <= dot;
            result_valid <= 1'b1;
            state        <= DOT_IDLE;
          end
        end
        default: state <= DOT_IDLE;
      endcase
    end
  end

  // Bases latched once per accepted run
  always_ff @(posedge clk_100mhz) begin
    if (run && state == DOT_IDLE) begin
      x_base <= run_cmd.x_base;
      w_base <= run_cmd.w_base;
    end
  end

endmodule

`default_nettype wire

/* source/tern_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tern_top import tern_pkg::*; #(
  parameter int CLKS_PER_BIT = 868  // 115200 baud at 100 MHz
) (
  input  logic clk_100mhz,
  input  logic rst_n,
  input  logic uart_rxd,
  output sum_t result,
  output logic result_valid
);

  logic       rx_valid;
  logic [7:0] rx_byte;

  logic       wr_req, wr_gnt;
  mem_req_t   wr_bus;
  logic       run;
  run_cmd_t   run_cmd;

  logic       x_req, x_gnt, x_rvalid, x_start, x_done;
  mem_req_t   x_bus;
  addr_t      x_base;
  x_vec_t     x_vec;

  logic       w_req, w_gnt, w_rvalid, w_start, w_done;
  mem_req_t   w_bus;
  addr_t      w_base;
  w_vec_t     w_vec;

  word_t      rdata, ram_rdata;  // Arbiter return, raw RAM output
  mem_req_t   ram_bus;
  logic       ram_en;

  uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx (
    .clk_100mhz, .rst_n, .rxd(uart_rxd), .byte_data(rx_byte), .byte_valid(rx_valid)
  );

  cmd_loader u_loader (
    .clk_100mhz, .rst_n, .byte_data(rx_byte), .byte_valid(rx_valid),
    .wr_req, .wr_bus, .wr_gnt, .run, .run_cmd
  );

  mem_arbiter u_arb (
    .clk_100mhz, .rst_n, .wr_req, .wr_bus, .wr_gnt,
    .x_req, .x_bus, .x_gnt, .x_rvalid, .w_req, .w_bus, .w_gnt, .w_rvalid,
    .rdata, .ram_bus, .ram_en, .ram_rdata
  );

  word_ram u_ram (.clk_100mhz, .ram_en, .ram_bus, .ram_rdata);

  word_gatherer #(.payload_t(x_vec_t)) x_gather (  // Two words
    .clk_100mhz, .rst_n, .start(x_start), .base(x_base), .req(x_req), .bus(x_bus),
    .gnt(x_gnt), .rvalid(x_rvalid), .rdata, .done(x_done), .payload(x_vec)
  );

  word_gatherer #(.payload_t(w_vec_t)) w_gather (  // One word
    .clk_100mhz, .rst_n, .start(w_start), .base(w_base), .req(w_req), .bus(w_bus),
    .gnt(w_gnt), .rvalid(w_rvalid), .rdata, .done(w_done), .payload(w_vec)
  );

  ternary_dot u_dot (
    .clk_100mhz, .rst_n, .run, .run_cmd,
    .x_start, .x_base, .x_done, .x_vec, .w_start, .w_base, .w_done, .w_vec,
    .result, .result_valid
  );

endmodule

`default_nettype wire

/* tb/tern_sva.sv */
`timescale 1ns/10ps
`default_nettype none

module tern_sva import tern_pkg::*; (
  input logic     clk_100mhz,
  input logic     rst_n,
  input logic     wr_req,
  input logic     wr_gnt,
  input logic     x_req,
  input mem_req_t x_bus,
  input logic     x_gnt,
  input logic     x_rvalid,
  input logic     w_req,
  input mem_req_t w_bus,
  input logic     w_gnt,
  input logic     w_rvalid
);

  logic x_rd;  // Granted activation read
  logic w_rd;  // Granted weight read

  assign x_rd = x_gnt & ~x_bus.we;
  assign w_rd = w_gnt & ~w_bus.we;

  one_grant: assert property (@(posedge clk_100mhz) disable iff (!rst_n)
    $onehot0({wr_gnt, x_gnt, w_gnt}))
    else $error("more than one grant in a cycle");

  x_return: assert property (@(posedge clk_100mhz) disable iff (!rst_n)
    x_rd |-> ##2 x_rvalid)
    else $error("activation read return not exactly two cycles after grant");

  // Every return traces back to its own read
  x_return_src: assert property (@(posedge clk_100mhz) disable iff (!rst_n)
    x_rvalid |-> $past(x_rd, 2))
    else $error("activation read return without a read two cycles before");

  w_return: assert property (@(posedge clk_100mhz) disable iff (!rst_n)
    w_rd |-> ##2 w_rvalid)
    else $error("weight read return not exactly two cycles after grant");

  w_return_src: assert property (@(posedge clk_100mhz) disable iff (!rst_n)
    w_rvalid |-> $past(w_rd, 2))
    else $error("weight read return without a read two cycles before");

  // Grant only where asked
  no_idle_gnt: assert property (@(posedge clk_100mhz) disable iff (!rst_n)
    !(wr_gnt && !wr_req) && !(x_gnt && !x_req) && !(w_gnt && !w_req))
    else $error("grant given to an idle requester");

endmodule

bind mem_arbiter tern_sva u_sva (
  .clk_100mhz, .rst_n, .wr_req, .wr_gnt, .x_req, .x_bus, .x_gnt, .x_rvalid,
  .w_req, .w_bus, .w_gnt, .w_rvalid
);

`default_nettype wire

/* tb/tb_tern_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_tern_top import tern_pkg::*; ();

  localparam int CPB     = 8;    // Clocks per serial bit
  localparam int RES_TMO = 400;  // Cycles allowed from last run byte to result

  logic clk_100mhz;
  logic rst_n;
  logic uart_rxd;
  sum_t result;
  logic result_valid;

  word_t       mem_model [256];  // Mirror of the DUT word memory
  sum_t        exp_q [$];        // Expected sums, oldest first
  logic [31:0] lfsr;
  int          errors;
  int          checks;
  int          results_seen;

  tern_top #(.CLKS_PER_BIT(CPB)) dut (
    .clk_100mhz, .rst_n, .uart_rxd, .result, .result_valid
  );

  always #5 clk_100mhz = ~clk_100mhz;  // 100 MHz

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[62:0], fb};
    end
    return v;
  endfunction

  // Expected dot product from the mirror memory
  function automatic sum_t ref_dot(input addr_t xb, input addr_t wb);
    addr_t             xb_hi;
    x_vec_t            x;
    w_vec_t            w;
    logic [3:0]        f;
    logic signed [7:0] e;
    int                acc;
    xb_hi = xb + 8'd1;                     // Upper half wraps past 255
    x     = {mem_model[xb_hi], mem_model[xb]};
    w     = mem_model[wb];
    acc   = 0;
    for (int i = 0; i < N_ELEM; i++) begin
      f = w[4*i +: 4];
      e = x[8*i +: 8];
      if (f != 4'd0) begin
        if (f[3]) acc = acc - int'(e);     // 8 to 15, negative field
        else acc = acc + int'(e);          // 1 to 7
      end
    end
    return sum_t'(acc);
  endfunction

  // Entered on a falling edge, leaves on one
  task automatic drive_bit(input logic v);
    uart_rxd = v;
    repeat (CPB) @(negedge clk_100mhz);
  endtask

  task automatic send_byte(input logic [7:0] b);
    drive_bit(1'b0);                       // Start bit
    for (int i = 0; i < 8; i++) drive_bit(b[i]);  // LSB first
    drive_bit(1'b1);                       // Stop bit
  endtask

  task automatic write_word(input addr_t a, input word_t d);
    send_byte(OP_WRITE);
    send_byte(a);
    for (int i = 0; i < 8; i++) send_byte(d[8*i +: 8]);
    mem_model[a] = d;
  endtask

  task automatic run_and_check(input addr_t xb, input addr_t wb);
    int target;
    int waited;
    target = results_seen + 1;
    exp_q.push_back(ref_dot(xb, wb));
    send_byte(OP_RUN);
    send_byte(xb);
    send_byte(wb);
    waited = 0;
    while (results_seen < target && waited < RES_TMO) begin
      @(negedge clk_100mhz);
      waited++;
    end
    if (results_seen < target) begin
      errors++;
      $display("ERROR: no result_valid within %0d cycles of run x_base=%0d w_base=%0d",
               RES_TMO, xb, wb);
      exp_q.delete();                      // Drop the stale expectation
    end
  endtask

  task automatic check_ref(input addr_t xb, input addr_t wb, input sum_t want);
    checks++;
    assert (ref_dot(xb, wb) === want) else begin
      errors++;
      $display("FAILED t=%0t ref_dot expected=%0d actual=%0d", $time, want, ref_dot(xb, wb));
    end
  endtask

  // Compares every result pulse with the oldest expectation
  always @(negedge clk_100mhz) begin : compare_results
    sum_t want;
    if (rst_n && result_valid) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("ERROR: result_valid at %0t with no run pending", $time);
      end else begin
        want = exp_q.pop_front();
        checks++;
        assert (result === want) else begin
          errors++;
          $display("FAILED t=%0t result expected=%0d actual=%0d", $time, want, result);
        end
        results_seen++;
      end
    end
  end

  initial begin : stimulus
    addr_t xb;
    addr_t wb;
    clk_100mhz   = 1'b0;
    rst_n        = 1'b0;
    uart_rxd     = 1'b1;                   // Line idles high
    lfsr         = 32'h9042_8f66;
    errors       = 0;
    checks       = 0;
    results_seen = 0;
    repeat (2) @(posedge clk_100mhz);
    @(negedge clk_100mhz);
    rst_n = 1'b1;

    // Quiet after reset, unknown opcodes ignored
    repeat (20) @(negedge clk_100mhz);
    checks++;
    assert (result === '0) else begin
      errors++;
      $display("FAILED t=%0t result expected=0 actual=%0d", $time, result);
    end
    send_byte(8'h5a);
    send_byte(8'hff);
    checks++;
    assert (result === '0) else begin
      errors++;
      $display("FAILED t=%0t result expected=0 actual=%0d", $time, result);
    end

    // Extremes
    write_word(8'd10, {8{8'h7f}});
    write_word(8'd11, {8{8'h7f}});
    write_word(8'd12, {16{4'h1}});
    check_ref(8'd10, 8'd12, 16'sd2032);
    run_and_check(8'd10, 8'd12);
    write_word(8'd20, {8{8'h80}});
    write_word(8'd21, {8{8'h80}});
    write_word(8'd22, {16{4'hf}});
    check_ref(8'd20, 8'd22, 16'sd2048);
    run_and_check(8'd20, 8'd22);

    // Trit rule over every field value
    write_word(8'd30, 64'h0807_0605_0403_0201);
    write_word(8'd31, 64'h100f_0e0d_0c0b_0a09);
    write_word(8'd32, 64'hfedc_ba98_7654_3210);
    check_ref(8'd30, 8'd32, -16'sd65);
    run_and_check(8'd30, 8'd32);
    write_word(8'd33, 64'h0);
    run_and_check(8'd30, 8'd33);           // Zero fields, zero sum
    write_word(8'd34, 64'h7654_3210_fedc_ba98);
    run_and_check(8'd30, 8'd34);

    // Rewritten weights take effect
    write_word(8'd12, {16{4'h9}});
    run_and_check(8'd10, 8'd12);

    // Activation pair wraps from 255 to 0
    write_word(8'd255, rand_bits(64));
    write_word(8'd0, rand_bits(64));
    write_word(8'd1, rand_bits(64));
    run_and_check(8'd255, 8'd1);

    // Random words and bases
    for (int n = 0; n < 10; n++) begin
      xb = addr_t'(rand_bits(8));
      wb = addr_t'(rand_bits(8));
      write_word(xb, rand_bits(64));
      write_word(xb + 8'd1, rand_bits(64));
      write_word(wb, rand_bits(64));
      write_word(addr_t'(rand_bits(8)), rand_bits(64));  // Unrelated traffic
      run_and_check(xb, wb);
    end

    repeat (20) @(negedge clk_100mhz);
    $display("Checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
source/tern_pkg.sv
source/uart_rx.sv
source/cmd_loader.sv
source/mem_arbiter.sv
source/word_ram.sv
source/word_gatherer.sv
source/ternary_dot.sv
source/tern_top.sv
tb/tern_sva.sv
tb/tb_tern_top.sv

/* Makefile */
TOP = tb_tern_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -Mdir obj_dir -o sim_$(TOP)

run: compile
	@out=$$(./obj_dir/sim_$(TOP)); echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir
